// File: common/alut_pkg.sv
// register map, command encoding and shared widths of the address lookup table
package alut_pkg;

   // widths of the frame fields
   parameter int MAC_W   = 48;   // mac address
   parameter int PORT_W  = 2;    // switch port number
   parameter int TIME_W  = 32;   // timestamp and age
   parameter int DPORT_W = 5;    // 4 switch ports plus cpu bit

   // ----------------------------------------------------------
   // apb register offsets, byte addressed
   // ----------------------------------------------------------
   typedef enum logic [6:0] {
      al_frm_d_addr_l   = 7'h00,   // dest addr bits 31:0
      al_frm_d_addr_u   = 7'h04,   // dest addr bits 47:32
      al_frm_s_addr_l   = 7'h08,
      al_frm_s_addr_u   = 7'h0c,
      al_s_port         = 7'h10,
      al_d_port         = 7'h14,   // lookup result, read only
      al_mac_addr_l     = 7'h18,   // switch own address
      al_mac_addr_u     = 7'h1c,
      al_cur_time       = 7'h20,   // read only
      al_bb_age         = 7'h24,
      al_div_clk        = 7'h28,
      al_status         = 7'h2c,   // active, inval in prog, reused
      al_command        = 7'h30,   // reads zero
      al_lst_inv_addr_l = 7'h34,
      al_lst_inv_addr_u = 7'h38,
      al_lst_inv_port   = 7'h3c
   } reg_addr_e;

   // command register encoding
   typedef enum logic [1:0] {
      cmd_none  = 2'd0,
      cmd_check = 2'd1,   // learn source, look up destination
      cmd_age   = 2'd2,   // drop stale entries
      cmd_clear = 2'd3    // drop every entry
   } command_e;

endpackage

// File: design/alut_timebase.sv
// time base: programmable prescaler and free running current time counter
`timescale 1ns/1ps

module alut_timebase
   import alut_pkg::*;
(
   input  logic              pclk7,
   input  logic              n_p_reset7,
   input  logic [7:0]        div_clk,      // time tick every div_clk+1 cycles
   output logic [TIME_W-1:0] curr_time
);

   logic [7:0] prescale;   // cycles since last tick

   // prescaler restarts on reaching the divider
   // >= so a smaller divider written mid count still wraps
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
      begin
         prescale  <= 8'd0;
         curr_time <= '0;
      end
      else if (prescale >= div_clk)
      begin
         prescale  <= 8'd0;
         curr_time <= curr_time + 1'b1;   // wraps at 2**32
      end
      else
      begin
         prescale  <= prescale + 1'b1;
      end
   end

endmodule

// File: alut/alut_reg_bank.sv
// apb register bank: write decode, self clearing command, status,
// last invalidated capture and registered read mux
`timescale 1ns/1ps

module alut_reg_bank
   import alut_pkg::*;
(
   input  logic               pclk7,
   input  logic               n_p_reset7,
   input  logic               psel7,
   input  logic               penable7,
   input  logic               pwrite7,
   input  logic [6:0]         paddr7,
   input  logic [31:0]        pwdata7,
   input  logic [TIME_W-1:0]  curr_time,
   input  logic               add_check_active,
   input  logic               age_check_active,
   input  logic               inval_in_prog,      // status bit 1
   input  logic               reused,             // status bit 2
   input  logic [DPORT_W-1:0] d_port,
   input  logic [MAC_W-1:0]   lst_inv_addr_nrm,   // overwritten by a learn
   input  logic [PORT_W-1:0]  lst_inv_port_nrm,
   input  logic [MAC_W-1:0]   lst_inv_addr_cmd,   // dropped by age or clear
   input  logic [PORT_W-1:0]  lst_inv_port_cmd,
   output logic [MAC_W-1:0]   mac_addr,
   output logic [MAC_W-1:0]   d_addr,
   output logic [MAC_W-1:0]   s_addr,
   output logic [PORT_W-1:0]  s_port,
   output logic [TIME_W-1:0]  best_bfr_age,
   output logic [7:0]         div_clk,
   output command_e           command,
   output logic [31:0]        prdata7,
   output logic               clear_reused,
   output logic               status_active
);

   logic        read_enable;    // setup phase of a read
   logic        write_enable;   // access phase of a write
   logic [31:0] frm_d_addr_l;
   logic [15:0] frm_d_addr_u;
   logic [31:0] frm_s_addr_l;
   logic [15:0] frm_s_addr_u;
   logic [31:0] mac_addr_l;
   logic [15:0] mac_addr_u;
   logic [MAC_W-1:0]  lst_inv_addr;
   logic [PORT_W-1:0] lst_inv_port;

   assign read_enable  = psel7 & ~penable7 & ~pwrite7;
   assign write_enable = psel7 & penable7 & pwrite7;

   assign mac_addr = {mac_addr_u, mac_addr_l};
   assign d_addr   = {frm_d_addr_u, frm_d_addr_l};
   assign s_addr   = {frm_s_addr_u, frm_s_addr_l};

   assign status_active = add_check_active | age_check_active;
   // reading status while idle acknowledges the reused flag
   assign clear_reused  = read_enable & (paddr7 == al_status) & ~status_active;

   // ----------------------------------------------------------
   // writable registers
   // ----------------------------------------------------------
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
      begin
         frm_d_addr_l <= '0;
         frm_d_addr_u <= '0;
         frm_s_addr_l <= '0;
         frm_s_addr_u <= '0;
         s_port       <= '0;
         mac_addr_l   <= '0;
         mac_addr_u   <= '0;
         best_bfr_age <= '1;   // nothing ages until programmed
         div_clk      <= '0;
      end
      else if (write_enable)
      begin
         case (paddr7)
            al_frm_d_addr_l : frm_d_addr_l <= pwdata7;
            al_frm_d_addr_u : frm_d_addr_u <= pwdata7[15:0];   // upper halves 16 bit
            al_frm_s_addr_l : frm_s_addr_l <= pwdata7;
            al_frm_s_addr_u : frm_s_addr_u <= pwdata7[15:0];
            al_s_port       : s_port       <= pwdata7[PORT_W-1:0];
            al_mac_addr_l   : mac_addr_l   <= pwdata7;
            al_mac_addr_u   : mac_addr_u   <= pwdata7[15:0];
            al_bb_age       : best_bfr_age <= pwdata7;
            al_div_clk      : div_clk      <= pwdata7[7:0];
            default         : ;   // read only or unmapped
         endcase
      end
   end

   // command is a single cycle pulse, dropped while a check runs
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
         command <= cmd_none;
      else if (command != cmd_none)
         command <= cmd_none;   // self clear
      else if (write_enable & (paddr7 == al_command) & ~status_active)
         command <= command_e'(pwdata7[1:0]);
   end

   // ----------------------------------------------------------
   // last invalidated entry, overwrite beats sweep
   // ----------------------------------------------------------
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (reused)
      begin
         lst_inv_addr <= lst_inv_addr_nrm;
         lst_inv_port <= lst_inv_port_nrm;
      end
      else if (inval_in_prog)
      begin
         lst_inv_addr <= lst_inv_addr_cmd;
         lst_inv_port <= lst_inv_port_cmd;
      end
   end

   // read mux, decoded in setup so data is there in access
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
         prdata7 <= '0;
      else if (read_enable)
      begin
         case (paddr7)
            al_frm_d_addr_l   : prdata7 <= frm_d_addr_l;
            al_frm_d_addr_u   : prdata7 <= {16'd0, frm_d_addr_u};
            al_frm_s_addr_l   : prdata7 <= frm_s_addr_l;
            al_frm_s_addr_u   : prdata7 <= {16'd0, frm_s_addr_u};
            al_s_port         : prdata7 <= {30'd0, s_port};
            al_d_port         : prdata7 <= {27'd0, d_port};
            al_mac_addr_l     : prdata7 <= mac_addr_l;
            al_mac_addr_u     : prdata7 <= {16'd0, mac_addr_u};
            al_cur_time       : prdata7 <= curr_time;
            al_bb_age         : prdata7 <= best_bfr_age;
            al_div_clk        : prdata7 <= {24'd0, div_clk};
            al_status         : prdata7 <= {29'd0, reused, inval_in_prog, status_active};
            al_lst_inv_addr_l : prdata7 <= lst_inv_addr[31:0];
            al_lst_inv_addr_u : prdata7 <= {16'd0, lst_inv_addr[47:32]};
            al_lst_inv_port   : prdata7 <= {30'd0, lst_inv_port};
            default           : prdata7 <= '0;   // command reads zero
         endcase
      end
      else
         prdata7 <= '0;   // bus quiet outside reads
   end

endmodule

// File: alut/alut_addr_checker.sv
// address checker: direct mapped table, destination lookup, source learning
// and overwrite detection
`timescale 1ns/1ps

module alut_addr_checker
   import alut_pkg::*;
#(
   parameter int table_depth = 4
)
(
   input  logic                            pclk7,
   input  logic                            n_p_reset7,
   input  command_e                        command,
   input  logic [MAC_W-1:0]                s_addr,
   input  logic [PORT_W-1:0]               s_port,
   input  logic [MAC_W-1:0]                d_addr,
   input  logic [MAC_W-1:0]                mac_addr,
   input  logic [TIME_W-1:0]               curr_time,
   input  logic                            clear_reused,
   input  logic                            inval_strobe,   // from age checker
   input  logic [$clog2(table_depth)-1:0]  inval_index,
   output logic                            add_check_active,
   output logic [DPORT_W-1:0]              d_port,
   output logic                            reused,         // sticky
   output logic [MAC_W-1:0]                lst_inv_addr_nrm,
   output logic [PORT_W-1:0]               lst_inv_port_nrm,
   output logic [table_depth-1:0]          entry_valid,
   output logic [table_depth*MAC_W-1:0]    entry_addr,
   output logic [table_depth*PORT_W-1:0]   entry_port,
   output logic [table_depth*TIME_W-1:0]   entry_stamp
);

   localparam int idx_w = $clog2(table_depth);

   typedef enum logic [1:0] {idle, lookup, learn} chk_state_e;

   chk_state_e        state;
   logic [MAC_W-1:0]  tbl_addr  [table_depth];
   logic [PORT_W-1:0] tbl_port  [table_depth];
   logic [TIME_W-1:0] tbl_stamp [table_depth];
   logic [idx_w-1:0]  s_idx;       // low source bits, no hashing
   logic [idx_w-1:0]  d_idx;
   logic              d_hit;
   logic              overwrite;   // learn displaces another address

   assign s_idx     = s_addr[idx_w-1:0];
   assign d_idx     = d_addr[idx_w-1:0];
   assign d_hit     = entry_valid[d_idx] && (tbl_addr[d_idx] == d_addr);
   assign overwrite = entry_valid[s_idx] && (tbl_addr[s_idx] != s_addr);

   assign add_check_active = (state != idle);   // lookup + learn, 2 cycles

   // ----------------------------------------------------------
   // check sequencer
   // ----------------------------------------------------------
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
         state <= idle;
      else
      begin
         case (state)
            idle    : if (command == cmd_check) state <= lookup;
            lookup  : state <= learn;
            default : state <= idle;   // learn done
         endcase
      end
   end

   // lookup result
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
         d_port <= '0;
      else if (state == lookup)
      begin
         if (d_addr == mac_addr)
            d_port <= 5'b1_0000;   // for the switch cpu
         else if (d_hit)
            d_port <= DPORT_W'(1) << tbl_port[d_idx];
         else
            d_port <= {1'b0, ~(4'b0001 << s_port)};   // flood, not back to source
      end
   end

   // valid bits and sticky reused flag
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
      begin
         entry_valid <= '0;
         reused      <= 1'b0;
      end
      else
      begin
         if (inval_strobe)
            entry_valid[inval_index] <= 1'b0;
         if (state == learn)
            entry_valid[s_idx] <= 1'b1;
         if ((state == learn) && overwrite)
            reused <= 1'b1;
         else if (clear_reused)
            reused <= 1'b0;
      end
   end

   // table payload and displaced entry
   always_ff @(posedge pclk7)
   begin
      if (state == learn)
      begin
         if (overwrite)
         begin
            lst_inv_addr_nrm <= tbl_addr[s_idx];
            lst_inv_port_nrm <= tbl_port[s_idx];
         end
         tbl_addr[s_idx]  <= s_addr;      // same addr just restamps
         tbl_port[s_idx]  <= s_port;
         tbl_stamp[s_idx] <= curr_time;
      end
   end

   // flattened view for the age checker
   for (genvar i = 0; i < table_depth; i++)
   begin : g_flat
      assign entry_addr[i*MAC_W +: MAC_W]    = tbl_addr[i];
      assign entry_port[i*PORT_W +: PORT_W]  = tbl_port[i];
      assign entry_stamp[i*TIME_W +: TIME_W] = tbl_stamp[i];
   end

endmodule

// File: alut/alut_age_checker.sv
// age checker: one entry per cycle sweep for the age and clear commands
`timescale 1ns/1ps

module alut_age_checker
   import alut_pkg::*;
#(
   parameter int table_depth = 4
)
(
   input  logic                            pclk7,
   input  logic                            n_p_reset7,
   input  command_e                        command,
   input  logic [TIME_W-1:0]               curr_time,
   input  logic [TIME_W-1:0]               best_bfr_age,
   input  logic [table_depth-1:0]          entry_valid,
   input  logic [table_depth*MAC_W-1:0]    entry_addr,
   input  logic [table_depth*PORT_W-1:0]   entry_port,
   input  logic [table_depth*TIME_W-1:0]   entry_stamp,
   output logic                            age_check_active,
   output logic                            inval_in_prog,   // status bit 1
   output logic                            inval_strobe,    // to address checker
   output logic [$clog2(table_depth)-1:0]  inval_index,
   output logic [MAC_W-1:0]                lst_inv_addr_cmd,
   output logic [PORT_W-1:0]               lst_inv_port_cmd
);

   localparam int idx_w = $clog2(table_depth);

   typedef enum logic {idle, sweep} age_state_e;

   age_state_e        state;
   logic [idx_w-1:0]  sweep_idx;    // entry under test
   logic              clear_mode;   // latched at sweep start
   logic [TIME_W-1:0] entry_age;
   logic              drop;

   // ----------------------------------------------------------
   // sweep sequencer
   // ----------------------------------------------------------
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
      begin
         state      <= idle;
         sweep_idx  <= '0;
         clear_mode <= 1'b0;
      end
      else if (state == idle)
      begin
         if ((command == cmd_age) || (command == cmd_clear))
         begin
            state      <= sweep;
            sweep_idx  <= '0;
            clear_mode <= (command == cmd_clear);
         end
      end
      else
      begin
         sweep_idx <= sweep_idx + 1'b1;
         if (sweep_idx == idx_w'(table_depth - 1))
            state <= idle;   // last entry tested
      end
   end

   assign age_check_active = (state == sweep);

   // modulo 2**32 difference survives a timer wrap
   assign entry_age = curr_time - entry_stamp[sweep_idx*TIME_W +: TIME_W];
   assign drop      = age_check_active && entry_valid[sweep_idx]
                      && (clear_mode || (entry_age > best_bfr_age));

   assign inval_strobe     = drop;
   assign inval_in_prog    = drop;
   assign inval_index      = sweep_idx;
   assign lst_inv_addr_cmd = entry_addr[sweep_idx*MAC_W +: MAC_W];
   assign lst_inv_port_cmd = entry_port[sweep_idx*PORT_W +: PORT_W];

endmodule

// File: alut/alut.sv
// alut top level: register bank, time base, address and age checkers
`timescale 1ns/1ps

module alut
   import alut_pkg::*;
#(
   parameter int table_depth = 4   // power of two
)
(
   input  logic               pclk7,
   input  logic               n_p_reset7,
   input  logic               psel7,
   input  logic               penable7,
   input  logic               pwrite7,
   input  logic [6:0]         paddr7,
   input  logic [31:0]        pwdata7,
   output logic [31:0]        prdata7,
   output logic               status_active,   // software polls this
   output logic               inval_in_prog,
   output logic [DPORT_W-1:0] d_port
);

   localparam int idx_w = $clog2(table_depth);

   // ----------------------------------------------------------
   // interconnect
   // ----------------------------------------------------------
   logic [MAC_W-1:0]              mac_addr;
   logic [MAC_W-1:0]              d_addr;
   logic [MAC_W-1:0]              s_addr;
   logic [PORT_W-1:0]             s_port;
   logic [TIME_W-1:0]             best_bfr_age;
   logic [7:0]                    div_clk;
   command_e                      command;
   logic                          clear_reused;
   logic [TIME_W-1:0]             curr_time;
   logic                          add_check_active;
   logic                          age_check_active;
   logic                          reused;
   logic [MAC_W-1:0]              lst_inv_addr_nrm;
   logic [PORT_W-1:0]             lst_inv_port_nrm;
   logic [MAC_W-1:0]              lst_inv_addr_cmd;
   logic [PORT_W-1:0]             lst_inv_port_cmd;
   logic [table_depth-1:0]        entry_valid;   // table view for aging
   logic [table_depth*MAC_W-1:0]  entry_addr;
   logic [table_depth*PORT_W-1:0] entry_port;
   logic [table_depth*TIME_W-1:0] entry_stamp;
   logic                          inval_strobe;
   logic [idx_w-1:0]              inval_index;

   alut_reg_bank i_reg_bank (.*);

   alut_timebase i_timebase (.*);

   alut_addr_checker #(.table_depth(table_depth)) i_addr_checker (.*);

   alut_age_checker #(.table_depth(table_depth)) i_age_checker (.*);

endmodule

// File: verif/alut_assertions.sv
// concurrent checks on apb timing, the command pulse and check durations
`timescale 1ns/1ps

module alut_assertions
   import alut_pkg::*;
#(
   parameter int table_depth = 4
)
(
   input logic        pclk7,
   input logic        n_p_reset7,
   input logic        psel7,
   input logic        penable7,
   input logic        pwrite7,
   input logic [31:0] prdata7,
   input command_e    command,
   input logic        add_check_active,
   input logic        age_check_active
);

   logic [7:0] add_run;   // consecutive cycles of add_check_active
   logic [7:0] age_run;
   logic       any_failed;   // polled by the testbench
   bit cmd_bad   = 1'b0;
   bit phase_bad = 1'b0;
   bit rdata_bad = 1'b0;
   bit add_bad   = 1'b0;
   bit age_bad   = 1'b0;

   assign any_failed = cmd_bad | phase_bad | rdata_bad | add_bad | age_bad;

   // run length counters, zero while low
   always_ff @(posedge pclk7 or negedge n_p_reset7)
   begin
      if (!n_p_reset7)
      begin
         add_run <= '0;
         age_run <= '0;
      end
      else
      begin
         add_run <= add_check_active ? add_run + 1'b1 : 8'd0;
         age_run <= age_check_active ? age_run + 1'b1 : 8'd0;
      end
   end

   // ----------------------------------------------------------
   // properties
   // ----------------------------------------------------------
   cmd_pulse : assert property (@(posedge pclk7) disable iff (!n_p_reset7)
      (command != cmd_none) |=> (command == cmd_none))
      else
      begin
         cmd_bad = 1'b1;
         $error("command held for more than one cycle");
      end

   // access only after a setup in the same direction
   apb_phase : assert property (@(posedge pclk7) disable iff (!n_p_reset7)
      (psel7 && penable7) |-> ($past(psel7 && !penable7) && $stable(pwrite7)))
      else
      begin
         phase_bad = 1'b1;
         $error("apb access without a setup phase in the same direction");
      end

   rdata_quiet : assert property (@(posedge pclk7) disable iff (!n_p_reset7)
      !(psel7 && penable7 && !pwrite7) |-> (prdata7 == 32'd0))
      else
      begin
         rdata_bad = 1'b1;
         $error("prdata7 nonzero outside a read access");
      end

   add_len : assert property (@(posedge pclk7) disable iff (!n_p_reset7)
      $fell(add_check_active) |-> (add_run == 8'd2))
      else
      begin
         add_bad = 1'b1;
         $error("add_check_active not 2 cycles long");
      end

   age_len : assert property (@(posedge pclk7) disable iff (!n_p_reset7)
      $fell(age_check_active) |-> (age_run == 8'(table_depth)))
      else
      begin
         age_bad = 1'b1;
         $error("age_check_active not table_depth cycles long");
      end

endmodule

bind alut alut_assertions #(.table_depth(table_depth)) i_assertions (.*);

// File: verif/alut_tb.sv
// alut testbench: clock, reset, apb tasks, directed lookup, reuse, clear and aging runs
`timescale 1ns/1ps

module alut_tb
   import alut_pkg::*;
();

   localparam int max_cycles = 2000;   // about 3x the scenario length

   logic        pclk7;
   logic        n_p_reset7;
   logic        psel7;
   logic        penable7;
   logic        pwrite7;
   logic [6:0]  paddr7;
   logic [31:0] pwdata7;
   logic [31:0] prdata7;
   logic        status_active;
   logic        inval_in_prog;
   logic [4:0]  d_port;
   integer      seed = 32'h4511;
   int          cycles = 0;
   int          inval_pulses = 0;
   int          pulses_before;
   logic [31:0] t0;
   logic [31:0] t1;
   logic [47:0] mac, a, b, c, d, u, e, f, a2, b2, g;

   alut #(.table_depth(4)) i_dut (.*);

   initial
   begin
      pclk7 = 1'b0;
      forever #50 pclk7 = ~pclk7;   // 100 ns period
   end

   // ----------------------------------------------------------
   // failure handling and monitors
   // ----------------------------------------------------------
   task automatic abort_run();
      $display("Errors found");
      $fatal(1, "run stopped at the first failure");
   endtask

   always @(posedge pclk7)
   begin
      cycles <= cycles + 1;
      if (cycles == max_cycles)
      begin
         $display("timeout after %0d cycles, the DUT never went idle", max_cycles);
         abort_run();
      end
   end

   always @(negedge pclk7)
   begin
      if (inval_in_prog)
         inval_pulses++;   // one per invalidated entry
      if (i_dut.i_assertions.any_failed)
      begin
         $display("a bound assertion in the DUT failed");
         abort_run();
      end
   end

   // ----------------------------------------------------------
   // apb access and register helpers
   // ----------------------------------------------------------
   task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
      @(posedge pclk7);
      psel7 <= 1'b1; // setup
      pwrite7 <= 1'b1;
      paddr7 <= addr;
      pwdata7 <= data;
      @(posedge pclk7);
      penable7 <= 1'b1;   // access
      @(posedge pclk7);
      psel7 <= 1'b0;
      penable7 <= 1'b0;
      pwrite7 <= 1'b0;
   endtask

   task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
      @(posedge pclk7);
      psel7 <= 1'b1;
      paddr7 <= addr;
      @(posedge pclk7);
      penable7 <= 1'b1;
      @(negedge pclk7);
      data = prdata7;   // mid access, registered data stable
      @(posedge pclk7);
      psel7 <= 1'b0;
      penable7 <= 1'b0;
   endtask

   task automatic expect_reg(input reg_addr_e addr, input logic [31:0] exp);
      logic [31:0] got;
      read_reg(addr, got);
      assert (got === exp)
      else
      begin
         $display("** Error at time %0t: %s expected %h, got %h", $time, addr.name(), exp, got);
         abort_run();
      end
   endtask

   task automatic write_check(input reg_addr_e addr, input logic [31:0] data,
                              input logic [31:0] exp);
      write_reg(addr, data);
      expect_reg(addr, exp);
   endtask

   // busy flag rises after the command, then falls when done
   task automatic wait_idle();
      do
         @(negedge pclk7);
      while (!status_active);
      do
         @(negedge pclk7);
      while (status_active);
   endtask

   task automatic run_cmd(input command_e cmd);
      write_reg(al_command, {30'd0, cmd});
      wait_idle();
   endtask

   task automatic run_check(input logic [47:0] s, input logic [1:0] sp, input logic [47:0] dst);
      write_reg(al_frm_s_addr_l, s[31:0]);
      write_reg(al_frm_s_addr_u, {16'd0, s[47:32]});
      write_reg(al_s_port, {30'd0, sp});
      write_reg(al_frm_d_addr_l, dst[31:0]);
      write_reg(al_frm_d_addr_u, {16'd0, dst[47:32]});
      run_cmd(cmd_check);
   endtask

   task automatic lookup(input logic [47:0] s, input logic [1:0] sp, input logic [47:0] dst,
                         input logic [4:0] exp);
      run_check(s, sp, dst);
      expect_reg(al_d_port, {27'd0, exp});
      assert (d_port === exp)   // result port agrees with the register
      else
      begin
         $display("** Error at time %0t: d_port expected %h, got %h", $time, exp, d_port);
         abort_run();
      end
   endtask

   // random address, low bits pick the table index
   task automatic make_mac(input logic [1:0] idx, output logic [47:0] m);
      logic [31:0] lo;
      logic [31:0] hi;
      lo = $random(seed);
      hi = $random(seed);
      m = {hi[15:0], lo[31:2], idx};
   endtask

   function automatic logic [4:0] flood_bits(input logic [1:0] sp);
      return 5'b01111 & ~(5'd1 << sp);   // all switch ports but the source
   endfunction

   function automatic logic [4:0] port_bit(input logic [1:0] p);
      return 5'd1 << p;
   endfunction

   task automatic expect_last_inv(input logic [47:0] m, input logic [1:0] p);
      expect_reg(al_lst_inv_addr_l, m[31:0]);
      expect_reg(al_lst_inv_addr_u, {16'd0, m[47:32]});
      expect_reg(al_lst_inv_port, {30'd0, p});
   endtask

   // ----------------------------------------------------------
   // scenarios
   // ----------------------------------------------------------
   initial
   begin
      n_p_reset7 = 1'b0;
      psel7 = 1'b0;
      penable7 = 1'b0;
      pwrite7 = 1'b0;
      paddr7 = '0;
      pwdata7 = '0;
      make_mac(2'd0, mac);
      make_mac(2'd0, a);
      make_mac(2'd1, b);
      make_mac(2'd2, c);
      make_mac(2'd3, d);
      make_mac(2'd3, u);   // never learned
      make_mac(2'd0, e);
      make_mac(2'd0, f);
      make_mac(2'd1, a2);
      make_mac(2'd2, b2);
      make_mac(2'd3, g);
      repeat (10) @(posedge pclk7);
      n_p_reset7 <= 1'b1;

      // register read back, narrow registers drop the upper write bits
      expect_reg(al_bb_age, 32'hffff_ffff);
      write_check(al_frm_d_addr_l, 32'h1234_5678, 32'h1234_5678);
      write_check(al_frm_d_addr_u, 32'hdead_beef, 32'h0000_beef);
      write_check(al_frm_s_addr_l, 32'h8765_4321, 32'h8765_4321);
      write_check(al_frm_s_addr_u, 32'hf00d_cafe, 32'h0000_cafe);
      write_check(al_s_port, 32'hffff_fffe, 32'd2);
      write_check(al_bb_age, 32'h0bad_f00d, 32'h0bad_f00d);
      write_check(al_div_clk, 32'h1234_565a, 32'h0000_005a);
      write_check(al_mac_addr_l, mac[31:0], mac[31:0]);
      write_check(al_mac_addr_u, {16'd0, mac[47:32]}, {16'd0, mac[47:32]});
      write_check(al_command, 32'hffff_fffc, 32'd0);   // low bits no command

      // learn three, then hit, flood and cpu
      run_check(a, 2'd1, u);
      run_check(b, 2'd2, u);
      run_check(c, 2'd3, u);
      lookup(d, 2'd0, b, port_bit(2'd2));
      lookup(d, 2'd0, u, flood_bits(2'd0));
      lookup(d, 2'd0, mac, 5'b10000);

      // overwrite of index 0 displaces a
      run_check(e, 2'd2, u);
      expect_reg(al_status, 32'h4);
      expect_last_inv(a, 2'd1);
      expect_reg(al_status, 32'h0);   // acked by the previous read

      // clear, everything floods
      run_cmd(cmd_clear);
      lookup(f, 2'd1, d, flood_bits(2'd1));
      lookup(f, 2'd1, e, flood_bits(2'd1));
      lookup(f, 2'd1, b, flood_bits(2'd1));
      lookup(f, 2'd1, c, flood_bits(2'd1));
      write_reg(al_div_clk, 32'd0);
      read_reg(al_cur_time, t0);
      repeat (10) @(posedge pclk7);
      read_reg(al_cur_time, t1);
      assert ((t1 - t0) >= 32'd10)
      else
      begin
         $display("** Error at time %0t: al_cur_time expected +10 or more, got %h then %h",
                  $time, t0, t1);
         abort_run();
      end

      // aging drops only the old entry
      run_cmd(cmd_clear);
      write_reg(al_bb_age, 32'd20);
      run_check(a2, 2'd2, u);
      repeat (40) @(posedge pclk7);
      run_check(b2, 2'd3, u);
      pulses_before = inval_pulses;
      run_cmd(cmd_age);
      assert ((inval_pulses - pulses_before) == 1)
      else
      begin
         $display("** Error at time %0t: inval_in_prog pulses expected 1, got %0d",
                  $time, inval_pulses - pulses_before);
         abort_run();
      end
      expect_last_inv(a2, 2'd2);
      lookup(g, 2'd0, a2, flood_bits(2'd0));
      lookup(g, 2'd0, b2, port_bit(2'd3));

      @(negedge pclk7);
      if (i_dut.i_assertions.any_failed)
         abort_run();
      else
      begin
         $display("No errors");
         $finish;
      end
   end

endmodule

// File: alut.f
common/alut_pkg.sv
design/alut_timebase.sv
alut/alut_reg_bank.sv
alut/alut_addr_checker.sv
alut/alut_age_checker.sv
alut/alut.sv
verif/alut_assertions.sv
verif/alut_tb.sv

// File: run_alut.sh
#!/bin/sh
# builds the alut testbench with verilator, runs it and searches the log for the pass line
cd "$(dirname "$0")" &&
rm -f alut_sim.log &&
verilator --binary --timing --assert -j 0 --top-module alut_tb -f alut.f &&
{ ./obj_dir/Valut_tb +verilator+error+limit+100 > alut_sim.log 2>&1 || true; } &&
cat alut_sim.log &&
grep -qx "No errors" alut_sim.log &&
echo "alut simulation passed" ||
{ echo "alut simulation failed, see alut_sim.log"; exit 1; }
